// File: src.f
logic/tp84_bus_pkg.sv
logic/tp84_addr_decode.sv
logic/tp84_latch_regs.sv
logic/tp84_shared_ram.sv
logic/tp84_read_mux.sv
logic/tp84_cpu_bus.sv
test/tp84_cpu_bus_properties.sv
test/tb_tp84_cpu_bus.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_tp84_cpu_bus
FILELIST  := src.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "No result line"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_tp84_cpu_bus.sv
`timescale 1ns/100ps

module tb_tp84_cpu_bus;

	localparam int ACK_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 10;

	logic clk_49m;
	logic reset;
	logic is_set3_i;
	logic bus_req_i;
	tp84_bus_pkg::cpu_addr_t bus_addr_i;
	logic bus_rw_i;
	tp84_bus_pkg::cpu_data_t bus_wdata_i;
	tp84_bus_pkg::cpu_data_t controls_dip_i;
	logic vblank_irq_i;
	logic bus_ack_o;
	tp84_bus_pkg::cpu_data_t bus_rdata_o;
	logic flip_h_o;
	logic flip_v_o;
	logic main_irq_n_o;
	tp84_bus_pkg::color_bank_t color_bank_o;
	tp84_bus_pkg::cpu_data_t scroll_x_o;
	tp84_bus_pkg::cpu_data_t scroll_y_o;
	tp84_bus_pkg::cpu_data_t sound_data_o;
	logic sound_data_we_o;
	logic sound_irq_o;

	// Expected RAM contents, shared by both maps
	tp84_bus_pkg::cpu_data_t ram_model [tp84_bus_pkg::RAM_DEPTH];
	int errors = 0;
	int timeouts = 0;
	event timeout_ev;

	tp84_cpu_bus u_tp84_cpu_bus (.*);

	initial begin
		clk_49m = 1'b0;
		forever #50 clk_49m = ~clk_49m;
	end

	// A stuck handshake ends the run here
	initial begin
		@(timeout_ev);
		$display(">>> FAIL");
		$finish;
	end

	task automatic report_timeout(input string what);
		$display("ERROR at %0t: timed out waiting for %s", $time, what);
		timeouts++;
		-> timeout_ev;
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// ============================================================
	// Bus master, one four-phase handshake
	// ============================================================

	task automatic bus_cycle(input tp84_bus_pkg::cpu_addr_t addr, input logic rw,
		input tp84_bus_pkg::cpu_data_t wdata, output tp84_bus_pkg::cpu_data_t rdata);
		int cnt;
		@(negedge clk_49m);
		bus_req_i   = 1'b1;
		bus_addr_i  = addr;
		bus_rw_i    = rw;
		bus_wdata_i = wdata;
		cnt = 0;
		while (!bus_ack_o && cnt < ACK_TIMEOUT) begin
			@(negedge clk_49m);
			cnt++;
		end
		if (!bus_ack_o)
			report_timeout("ack to rise");
		rdata = bus_rdata_o;
		// Hold req one extra cycle so back-pressure is exercised
		@(negedge clk_49m);
		@(negedge clk_49m);
		bus_req_i = 1'b0;
		cnt = 0;
		while (bus_ack_o && cnt < ACK_TIMEOUT) begin
			@(negedge clk_49m);
			cnt++;
		end
		if (bus_ack_o)
			report_timeout("ack to fall");
	endtask

	task automatic bus_write(input tp84_bus_pkg::cpu_addr_t addr, input tp84_bus_pkg::cpu_data_t d);
		tp84_bus_pkg::cpu_data_t unused;
		bus_cycle(addr, 1'b0, d, unused);
	endtask

	task automatic read_expect(input tp84_bus_pkg::cpu_addr_t addr, input logic [7:0] exp);
		tp84_bus_pkg::cpu_data_t got;
		bus_cycle(addr, 1'b1, 8'h00, got);
		check_byte($sformatf("read of %h", addr), got, exp);
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	initial begin
		int off;
		int cnt;
		tp84_bus_pkg::cpu_data_t d;
		void'($urandom(5));
		reset = 1'b0;
		is_set3_i = 1'b0;
		bus_req_i = 1'b0;
		bus_addr_i = '0;
		bus_rw_i = 1'b1;
		bus_wdata_i = '0;
		controls_dip_i = 8'h5A;
		vblank_irq_i = 1'b0;
		repeat (10) @(negedge clk_49m);
		reset = 1'b1;

		// RAM in both maps, plus writes that miss the RAM region
		for (int i = 0; i < 12; i++) begin
			off = $urandom % tp84_bus_pkg::RAM_DEPTH;
			d = $urandom;
			is_set3_i = i[0];
			bus_write(is_set3_i ? 16'h1000 + off : 16'h5000 + off, d);
			ram_model[off] = d;
			read_expect(is_set3_i ? 16'h1000 + off : 16'h5000 + off, ram_model[off]);
			bus_write(is_set3_i ? 16'h5000 + off : 16'h1000 + off, ~d);
			read_expect(is_set3_i ? 16'h1000 + off : 16'h5000 + off, ram_model[off]);
		end

		// Main latch, colour, scroll and sound in the standard map
		is_set3_i = 1'b0;
		bus_write(16'h3004, 8'h01);
		check_byte("flip_v_o", {7'd0, flip_v_o}, 8'h01);
		bus_write(16'h3005, 8'h01);
		check_byte("flip_h_o", {7'd0, flip_h_o}, 8'h01);
		bus_write(16'h2800, 8'hF3);
		check_byte("color_bank_o", {3'd0, color_bank_o}, 8'h13);
		d = $urandom;
		bus_write(16'h3C00, d);
		check_byte("scroll_x_o", scroll_x_o, d);
		bus_write(16'h3E00, ~d);
		check_byte("scroll_y_o", scroll_y_o, ~d);
		bus_write(16'h3A00, d);
		check_byte("sound_data_o", sound_data_o, d);
		bus_write(16'h3800, 8'h00);

		// Set-3 overlaps hit two registers at once
		is_set3_i = 1'b1;
		d = $urandom;
		bus_write(16'h1F80, d);
		check_byte("scroll_x_o set3", scroll_x_o, d);
		check_byte("scroll_y_o set3", scroll_y_o, d);
		bus_write(16'h1E80, ~d);
		check_byte("sound_data_o set3", sound_data_o, ~d);
		bus_write(16'h1A00, 8'h0C);
		check_byte("color_bank_o set3", {3'd0, color_bank_o}, 8'h0C);
		bus_write(16'h1C04, 8'h00);
		check_byte("flip_v_o set3", {7'd0, flip_v_o}, 8'h00);

		// Main IRQ follows VBlank once unmasked
		bus_write(16'h1C00, 8'h01);
		@(negedge clk_49m);
		vblank_irq_i = 1'b1;
		@(negedge clk_49m);
		vblank_irq_i = 1'b0;
		cnt = 0;
		while (main_irq_n_o && cnt < IRQ_TIMEOUT) begin
			@(negedge clk_49m);
			cnt++;
		end
		if (main_irq_n_o)
			report_timeout("main_irq_n_o to go low");
		bus_write(16'h1C00, 8'h00);
		check_byte("main_irq_n_o", {7'd0, main_irq_n_o}, 8'h01);

		// Controls, DIP2, ROM and open bus reads
		controls_dip_i = $urandom;
		read_expect(16'h1A60 | ($urandom & 16'h000F), controls_dip_i);
		read_expect(16'h1C03, controls_dip_i);
		read_expect(16'h8000 | ($urandom & 16'h7FFF), tp84_bus_pkg::UNMAPPED_DATA);
		is_set3_i = 1'b0;
		read_expect(16'h2820 | ($urandom & 16'h000F), controls_dip_i);
		read_expect(16'h3000, controls_dip_i);
		read_expect(16'hC000 | ($urandom & 16'h3FFF), tp84_bus_pkg::UNMAPPED_DATA);
		read_expect(16'h4000, tp84_bus_pkg::UNMAPPED_DATA);

		repeat (4) @(negedge clk_49m);
		$display("Errors: %0d mismatches, %0d assertion failures, %0d timeouts", errors,
			u_tp84_cpu_bus.u_props.fail_count, timeouts);
		if (errors == 0 && timeouts == 0 && u_tp84_cpu_bus.u_props.fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: test/tp84_cpu_bus_properties.sv
`timescale 1ns/100ps

module tp84_cpu_bus_properties (
	input logic                      clk_49m,
	input logic                      reset,
	input logic                      bus_req_i,
	input logic                      bus_ack_o,
	input tp84_bus_pkg::bus_state_e  state,
	input logic                      access_active,
	input logic                      sel_main_latch,
	input logic                      sel_xscroll,
	input logic                      sel_yscroll,
	input logic                      sel_sound_irq,
	input logic                      sel_sound_data,
	input tp84_bus_pkg::cpu_addr_t   addr_q,
	input tp84_bus_pkg::cpu_data_t   wdata_q,
	input logic                      flip_h_o,
	input logic                      flip_v_o,
	input tp84_bus_pkg::cpu_data_t   scroll_x_o,
	input tp84_bus_pkg::cpu_data_t   scroll_y_o,
	input tp84_bus_pkg::cpu_data_t   sound_data_o,
	input logic                      sound_data_we_o,
	input logic                      sound_irq_o
);

	int fail_count = 0;

	// ============================================================
	// Handshake
	// ============================================================

	ack_after_reset: assert property (@(posedge clk_49m) $rose(reset) |-> !bus_ack_o)
		else begin $error("ack high after reset"); fail_count++; end

	// Ack two edges after the capture edge
	ack_latency: assert property (@(posedge clk_49m) disable iff (!reset)
		(state == tp84_bus_pkg::IDLE && bus_req_i) |=> !bus_ack_o ##1 !bus_ack_o ##1 bus_ack_o)
		else begin $error("ack latency wrong"); fail_count++; end

	ack_held: assert property (@(posedge clk_49m) disable iff (!reset)
		(bus_ack_o && bus_req_i) |=> bus_ack_o)
		else begin $error("ack dropped while req high"); fail_count++; end

	ack_release: assert property (@(posedge clk_49m) disable iff (!reset)
		(bus_ack_o && !bus_req_i) |=> !bus_ack_o)
		else begin $error("ack not released"); fail_count++; end

	// ============================================================
	// Register effects
	// ============================================================

	vflip_write: assert property (@(posedge clk_49m) disable iff (!reset)
		(access_active && sel_main_latch && addr_q[2:0] == tp84_bus_pkg::LATCH_VFLIP)
		|=> flip_v_o == $past(wdata_q[0]))
		else begin $error("flip_v_o not written"); fail_count++; end

	hflip_write: assert property (@(posedge clk_49m) disable iff (!reset)
		(access_active && sel_main_latch && addr_q[2:0] == tp84_bus_pkg::LATCH_HFLIP)
		|=> flip_h_o == $past(wdata_q[0]))
		else begin $error("flip_h_o not written"); fail_count++; end

	scroll_write: assert property (@(posedge clk_49m) disable iff (!reset)
		(access_active && sel_xscroll && sel_yscroll)
		|=> scroll_x_o == $past(wdata_q) && scroll_y_o == $past(wdata_q))
		else begin $error("overlapped scroll write missed"); fail_count++; end

	// Sound strobes last exactly one cycle
	sound_irq_fires: assert property (@(posedge clk_49m) disable iff (!reset)
		(access_active && sel_sound_irq) |=> sound_irq_o ##1 !sound_irq_o)
		else begin $error("sound_irq_o pulse wrong"); fail_count++; end

	// A sound data write raises the strobe on the next cycle
	sound_data_fires: assert property (@(posedge clk_49m) disable iff (!reset)
		(access_active && sel_sound_data) |=> sound_data_we_o)
		else begin $error("sound_data_we_o did not fire"); fail_count++; end

	sound_data_valid: assert property (@(posedge clk_49m) disable iff (!reset)
		sound_data_we_o |-> sound_data_o == $past(wdata_q) ##1 !sound_data_we_o)
		else begin $error("sound data strobe wrong"); fail_count++; end

endmodule

bind tp84_cpu_bus tp84_cpu_bus_properties u_props (.clk_49m(clk_49m), .reset(reset),
	.bus_req_i(bus_req_i), .bus_ack_o(bus_ack_o), .state(state),
	.access_active(access_active), .sel_main_latch(sel_main_latch),
	.sel_xscroll(sel_xscroll), .sel_yscroll(sel_yscroll), .sel_sound_irq(sel_sound_irq),
	.sel_sound_data(sel_sound_data),
	.addr_q(addr_q), .wdata_q(wdata_q), .flip_h_o(flip_h_o), .flip_v_o(flip_v_o),
	.scroll_x_o(scroll_x_o), .scroll_y_o(scroll_y_o), .sound_data_o(sound_data_o),
	.sound_data_we_o(sound_data_we_o), .sound_irq_o(sound_irq_o));

// File: logic/tp84_cpu_bus.sv
`timescale 1ns/100ps

module tp84_cpu_bus (
	input  logic                      clk_49m,
	input  logic                      reset,
	input  logic                      is_set3_i,
	input  logic                      bus_req_i,
	input  tp84_bus_pkg::cpu_addr_t   bus_addr_i,
	input  logic                      bus_rw_i,
	input  tp84_bus_pkg::cpu_data_t   bus_wdata_i,
	input  tp84_bus_pkg::cpu_data_t   controls_dip_i,
	input  logic                      vblank_irq_i,
	output logic                      bus_ack_o,
	output tp84_bus_pkg::cpu_data_t   bus_rdata_o,
	output logic                      flip_h_o,
	output logic                      flip_v_o,
	output logic                      main_irq_n_o,
	output tp84_bus_pkg::color_bank_t color_bank_o,
	output tp84_bus_pkg::cpu_data_t   scroll_x_o,
	output tp84_bus_pkg::cpu_data_t   scroll_y_o,
	output tp84_bus_pkg::cpu_data_t   sound_data_o,
	output logic                      sound_data_we_o,
	output logic                      sound_irq_o
);

	tp84_bus_pkg::bus_state_e state;
	// Bus values captured on the req edge
	tp84_bus_pkg::cpu_addr_t addr_q;
	tp84_bus_pkg::cpu_data_t wdata_q;
	logic rw_q;
	logic access_active;
	logic sel_ram, sel_main_latch, sel_color, sel_xscroll, sel_yscroll;
	logic sel_sound_irq, sel_sound_data, sel_inputs;
	tp84_bus_pkg::cpu_data_t ram_rdata;

	// ============================================================
	// Handshake sequencer
	// ============================================================

	// IDLE -> ACCESS -> RESPOND -> HOLD, back once req drops
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			state <= tp84_bus_pkg::IDLE;
		end else begin
			case (state)
				tp84_bus_pkg::IDLE:    if (bus_req_i) state <= tp84_bus_pkg::ACCESS;
				tp84_bus_pkg::ACCESS:  state <= tp84_bus_pkg::RESPOND;
				tp84_bus_pkg::RESPOND: state <= tp84_bus_pkg::HOLD;
				default:               if (!bus_req_i) state <= tp84_bus_pkg::IDLE;
			endcase
		end
	end

	// Capture once per handshake, master holds the bus anyway
	always_ff @(posedge clk_49m) begin
		if (state == tp84_bus_pkg::IDLE && bus_req_i) begin
			addr_q  <= bus_addr_i;
			rw_q    <= bus_rw_i;
			wdata_q <= bus_wdata_i;
		end
	end

	// Ack two edges after the capture edge
	assign bus_ack_o     = state == tp84_bus_pkg::HOLD;
	// Single-cycle strobe for every register and RAM effect
	assign access_active = state == tp84_bus_pkg::ACCESS;

	// ============================================================
	// Decode, registers, RAM and read path
	// ============================================================

	tp84_addr_decode u_decode (.is_set3_i(is_set3_i), .addr_i(addr_q), .rw_i(rw_q),
		.sel_ram_o(sel_ram), .sel_main_latch_o(sel_main_latch), .sel_color_o(sel_color),
		.sel_xscroll_o(sel_xscroll), .sel_yscroll_o(sel_yscroll),
		.sel_sound_irq_o(sel_sound_irq), .sel_sound_data_o(sel_sound_data),
		.sel_inputs_o(sel_inputs));

	tp84_latch_regs u_latch_regs (.clk_49m(clk_49m), .reset(reset), .access_i(access_active),
		.sel_main_latch_i(sel_main_latch), .sel_color_i(sel_color),
		.sel_xscroll_i(sel_xscroll), .sel_yscroll_i(sel_yscroll),
		.sel_sound_irq_i(sel_sound_irq), .sel_sound_data_i(sel_sound_data),
		.latch_addr_i(addr_q[2:0]), .wdata_i(wdata_q), .vblank_irq_i(vblank_irq_i),
		.flip_h_o(flip_h_o), .flip_v_o(flip_v_o), .main_irq_n_o(main_irq_n_o),
		.color_bank_o(color_bank_o), .scroll_x_o(scroll_x_o), .scroll_y_o(scroll_y_o),
		.sound_data_o(sound_data_o), .sound_data_we_o(sound_data_we_o),
		.sound_irq_o(sound_irq_o));

	// Write only in ACCESS and only on a write cycle
	tp84_shared_ram u_shared_ram (.clk_49m(clk_49m),
		.we_i(access_active & sel_ram & ~rw_q), .addr_i(addr_q[10:0]),
		.wdata_i(wdata_q), .rdata_o(ram_rdata));

	// RAM select passed on for reads only
	tp84_read_mux u_read_mux (.clk_49m(clk_49m), .reset(reset), .access_i(access_active),
		.sel_ram_i(sel_ram & rw_q), .sel_inputs_i(sel_inputs), .ram_rdata_i(ram_rdata),
		.controls_dip_i(controls_dip_i), .rdata_o(bus_rdata_o));

endmodule

// File: logic/tp84_read_mux.sv
`timescale 1ns/100ps

module tp84_read_mux (
	input  logic                    clk_49m,
	input  logic                    reset,
	input  logic                    access_i,
	input  logic                    sel_ram_i,
	input  logic                    sel_inputs_i,
	input  tp84_bus_pkg::cpu_data_t ram_rdata_i,
	input  tp84_bus_pkg::cpu_data_t controls_dip_i,
	output tp84_bus_pkg::cpu_data_t rdata_o
);

	// RAM read issued in ACCESS, data due in RESPOND
	logic ram_pending;

	// ============================================================
	// Read data register
	// ============================================================

	always_ff @(posedge clk_49m) begin
		if (!reset)
			ram_pending <= 1'b0;
		else
			ram_pending <= access_i & sel_ram_i;
	end

	// End of ACCESS loads controls or open bus
	// End of RESPOND swaps in the RAM byte when one was read
	// Held through HOLD
	always_ff @(posedge clk_49m) begin
		if (access_i) begin
			if (sel_inputs_i)
				rdata_o <= controls_dip_i;
			else
				rdata_o <= tp84_bus_pkg::UNMAPPED_DATA;
		end else if (ram_pending) begin
			rdata_o <= ram_rdata_i;
		end
	end

endmodule

// File: logic/tp84_shared_ram.sv
`timescale 1ns/100ps

module tp84_shared_ram (
	input  logic                    clk_49m,
	input  logic                    we_i,
	input  tp84_bus_pkg::ram_addr_t addr_i,
	input  tp84_bus_pkg::cpu_data_t wdata_i,
	output tp84_bus_pkg::cpu_data_t rdata_o
);

	// ============================================================
	// Work RAM, CPU port only
	// ============================================================

	tp84_bus_pkg::cpu_data_t mem [tp84_bus_pkg::RAM_DEPTH];

	// Write port
	always_ff @(posedge clk_49m) begin
		if (we_i)
			mem[addr_i] <= wdata_i;
	end

	// Read every cycle, data one clock after the address
	// Read-before-write on a shared address
	always_ff @(posedge clk_49m) begin
		rdata_o <= mem[addr_i];
	end

endmodule

// File: logic/tp84_latch_regs.sv
`timescale 1ns/100ps

module tp84_latch_regs (
	input  logic                      clk_49m,
	input  logic                      reset,
	input  logic                      access_i,
	input  logic                      sel_main_latch_i,
	input  logic                      sel_color_i,
	input  logic                      sel_xscroll_i,
	input  logic                      sel_yscroll_i,
	input  logic                      sel_sound_irq_i,
	input  logic                      sel_sound_data_i,
	input  logic [2:0]                latch_addr_i,
	input  tp84_bus_pkg::cpu_data_t   wdata_i,
	input  logic                      vblank_irq_i,
	output logic                      flip_h_o,
	output logic                      flip_v_o,
	output logic                      main_irq_n_o,
	output tp84_bus_pkg::color_bank_t color_bank_o,
	output tp84_bus_pkg::cpu_data_t   scroll_x_o,
	output tp84_bus_pkg::cpu_data_t   scroll_y_o,
	output tp84_bus_pkg::cpu_data_t   sound_data_o,
	output logic                      sound_data_we_o,
	output logic                      sound_irq_o
);

	// IRQ enable bit from the main latch
	logic irq_mask;

	// ============================================================
	// Main latch
	// ============================================================

	// Bit 0 of the data goes to one of three flops by sub-address
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			irq_mask <= 1'b0;
			flip_v_o <= 1'b0;
			flip_h_o <= 1'b0;
		end else if (access_i && sel_main_latch_i) begin
			case (latch_addr_i)
				tp84_bus_pkg::LATCH_IRQ_MASK: irq_mask <= wdata_i[0];
				tp84_bus_pkg::LATCH_VFLIP:    flip_v_o <= wdata_i[0];
				tp84_bus_pkg::LATCH_HFLIP:    flip_h_o <= wdata_i[0];
				default: ;
			endcase
		end
	end

	// ============================================================
	// Colour latch and scroll registers
	// ============================================================

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			color_bank_o <= '0;
			scroll_x_o   <= '0;
			scroll_y_o   <= '0;
		end else if (access_i) begin
			// Only the low five bits are wired on the board
			if (sel_color_i)
				color_bank_o <= wdata_i[4:0];
			// Set-3 0x1F8x writes both scrolls at once
			if (sel_xscroll_i)
				scroll_x_o <= wdata_i;
			if (sel_yscroll_i)
				scroll_y_o <= wdata_i;
		end
	end

	// ============================================================
	// Sound board strobes
	// ============================================================

	// Strobes last the one cycle after ACCESS
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			sound_data_we_o <= 1'b0;
			sound_irq_o     <= 1'b0;
		end else begin
			sound_data_we_o <= access_i & sel_sound_data_i;
			sound_irq_o     <= access_i & sel_sound_irq_i;
		end
	end

	// Data byte lines up with its write strobe
	always_ff @(posedge clk_49m) begin
		if (access_i && sel_sound_data_i)
			sound_data_o <= wdata_i;
	end

	// Main IRQ, active low, cleared only by dropping the mask
	always_ff @(posedge clk_49m) begin
		if (!reset)
			main_irq_n_o <= 1'b1;
		else if (!irq_mask)
			main_irq_n_o <= 1'b1;
		else if (vblank_irq_i)
			main_irq_n_o <= 1'b0;
	end

endmodule

// File: logic/tp84_addr_decode.sv
`timescale 1ns/100ps

module tp84_addr_decode (
	input  logic                    is_set3_i,
	input  tp84_bus_pkg::cpu_addr_t addr_i,
	input  logic                    rw_i,
	output logic                    sel_ram_o,
	output logic                    sel_main_latch_o,
	output logic                    sel_color_o,
	output logic                    sel_xscroll_o,
	output logic                    sel_yscroll_o,
	output logic                    sel_sound_irq_o,
	output logic                    sel_sound_data_o,
	output logic                    sel_inputs_o
);

	// Raw region hits before direction qualifying
	logic ram_hit;
	logic main_hit;
	logic color_hit;
	logic xscroll_hit;
	logic yscroll_hit;
	logic sound_irq_hit;
	logic sound_data_hit;
	logic ctrl_hit;
	logic [7:0] page;
	logic ctrl_low_ok;

	assign page = addr_i[15:8];
	// Controls repeat on every other 16-byte slot of the lower half page
	assign ctrl_low_ok = ~addr_i[7] & ~addr_i[4];

	// ============================================================
	// Region compare, set-3 relocates everything but the ROMs
	// ============================================================

	always_comb begin
		if (is_set3_i) begin
			ram_hit        = addr_i[15:11] == tp84_bus_pkg::SHARED_RAM_SET3;
			main_hit       = page == tp84_bus_pkg::MAIN_LATCH_SET3;
			color_hit      = page == tp84_bus_pkg::COLOR_LATCH_SET3;
			xscroll_hit    = page == tp84_bus_pkg::XSCROLL_SET3;
			yscroll_hit    = addr_i[15:4] == tp84_bus_pkg::YSCROLL_SET3;
			sound_irq_hit  = page == tp84_bus_pkg::SOUND_IRQ_SET3;
			sound_data_hit = addr_i[15:4] == tp84_bus_pkg::SOUND_DATA_SET3;
			ctrl_hit       = (page == tp84_bus_pkg::CONTROLS_SET3) & ctrl_low_ok;
		end else begin
			ram_hit        = addr_i[15:11] == tp84_bus_pkg::SHARED_RAM_STD;
			main_hit       = page == tp84_bus_pkg::MAIN_LATCH_STD;
			color_hit      = page == tp84_bus_pkg::COLOR_LATCH_STD;
			xscroll_hit    = page == tp84_bus_pkg::XSCROLL_STD;
			yscroll_hit    = page == tp84_bus_pkg::YSCROLL_STD;
			sound_irq_hit  = page == tp84_bus_pkg::SOUND_IRQ_STD;
			sound_data_hit = page == tp84_bus_pkg::SOUND_DATA_STD;
			ctrl_hit       = (page == tp84_bus_pkg::CONTROLS_STD) & ctrl_low_ok;
		end
	end

	// ============================================================
	// Direction qualifying
	// ============================================================

	// RAM is selected both ways, the top splits read and write
	assign sel_ram_o = ram_hit;

	// Latches and strobes are write only
	assign sel_main_latch_o = main_hit & ~rw_i;
	assign sel_color_o      = color_hit & ~rw_i;
	assign sel_xscroll_o    = xscroll_hit & ~rw_i;
	assign sel_yscroll_o    = yscroll_hit & ~rw_i;
	assign sel_sound_irq_o  = sound_irq_hit & ~rw_i;
	assign sel_sound_data_o = sound_data_hit & ~rw_i;

	// Controls/DIP1 plus DIP2 on a read of the main latch page
	assign sel_inputs_o = (ctrl_hit | main_hit) & rw_i;

endmodule

// File: logic/tp84_bus_pkg.sv
package tp84_bus_pkg;

	// ============================================================
	// Bus types
	// ============================================================

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [10:0] ram_addr_t;
	typedef logic [4:0]  color_bank_t;

	// Handshake sequencer, one access in flight at a time
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RESPOND,
		HOLD
	} bus_state_e;

	// 2 KB work RAM shared with the second CPU on the real board
	localparam int RAM_DEPTH = 2048;

	// Open bus and ROM space read back as all ones
	localparam cpu_data_t UNMAPPED_DATA = 8'hFF;

	// ============================================================
	// Memory map, standard and set-3 boards
	// ============================================================

	// Shared RAM compares address bits [15:11]
	localparam logic [4:0] SHARED_RAM_STD  = 5'b01010;
	localparam logic [4:0] SHARED_RAM_SET3 = 5'b00010;

	// Page compares on address bits [15:8]
	localparam logic [7:0] MAIN_LATCH_STD   = 8'h30;
	localparam logic [7:0] MAIN_LATCH_SET3  = 8'h1C;
	localparam logic [7:0] COLOR_LATCH_STD  = 8'h28;
	localparam logic [7:0] COLOR_LATCH_SET3 = 8'h1A;
	localparam logic [7:0] XSCROLL_STD      = 8'h3C;
	localparam logic [7:0] XSCROLL_SET3     = 8'h1F;
	localparam logic [7:0] SOUND_IRQ_STD    = 8'h38;
	localparam logic [7:0] SOUND_IRQ_SET3   = 8'h1E;
	localparam logic [7:0] YSCROLL_STD      = 8'h3E;
	localparam logic [7:0] SOUND_DATA_STD   = 8'h3A;
	// Set-3 places these two on a 16-byte range, bits [15:4]
	localparam logic [11:0] YSCROLL_SET3    = 12'h1F8;
	localparam logic [11:0] SOUND_DATA_SET3 = 12'h1E8;
	// Controls page, then bits 7 and 4 must be clear (0x0x/0x2x/0x4x/0x6x)
	localparam logic [7:0] CONTROLS_STD     = 8'h28;
	localparam logic [7:0] CONTROLS_SET3    = 8'h1A;

	// Main latch sub-addresses on bits [2:0]
	localparam logic [2:0] LATCH_IRQ_MASK = 3'd0;
	localparam logic [2:0] LATCH_VFLIP    = 3'd4;
	localparam logic [2:0] LATCH_HFLIP    = 3'd5;

endpackage
